// ==== common/safety_pkg.sv ====
//==========================================================================
// Shared constants and the safety state type of the safety island
// Imported by every RTL module and by the testbench
//==========================================================================

`default_nettype none

package safety_pkg;

    //======================================================================
    // Fault channels
    //======================================================================
    localparam int NUM_CHANNELS = 4;

    // Lower channel index wins the reporting priority
    localparam int CH_LOCKSTEP   = 0;
    localparam int CH_ECC        = 1;
    localparam int CH_WD_ERROR   = 2;
    localparam int CH_WD_TIMEOUT = 3;

    localparam int SYNC_STAGES = 3;
    localparam int CODE_WIDTH  = 32;

    //======================================================================
    // Error accumulator
    //======================================================================
    localparam int ACC_WIDTH  = 8;
    // Error cycles tolerated in warning before going safe
    localparam int WARN_LIMIT = 100;

    //======================================================================
    // Interrupt vector layout
    //======================================================================
    localparam int IRQ_WIDTH    = 6;
    localparam int IRQ_LOCKSTEP = 0;
    localparam int IRQ_ECC      = 1;
    localparam int IRQ_WATCHDOG = 2;
    localparam int IRQ_DETECTED = 3;
    localparam int IRQ_SAFE     = 4;
    localparam int IRQ_FAULT    = 5;

    typedef enum logic [2:0] {
        ST_NORMAL  = 3'd0,
        ST_WARNING = 3'd1,
        ST_SAFE    = 3'd2,
        ST_RESET   = 3'd3,
        ST_FAULT   = 3'd4
    } safety_state_t;

endpackage

`default_nettype wire

// ==== src/fault_channel.sv ====
//==========================================================================
// One fault channel that brings an asynchronous fault line into the
// safety clock domain and captures its error code on the synchronized rise
// Instantiated once per fault source by the top level
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module fault_channel (
    input  logic                                clk_safety_gated,
    input  logic                                rst_n_safety_i,
    input  logic                                fault_i,
    input  logic [safety_pkg::CODE_WIDTH-1:0]   fault_code_i,
    output logic                                fault_level_o,
    output logic                                fault_rise_o,
    output logic [safety_pkg::CODE_WIDTH-1:0]   fault_code_o
);

    import safety_pkg::*;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   level_d1_q;
    logic                   rise_next;
    logic [CODE_WIDTH-1:0]  code_q;

    //======================================================================
    // Synchronizer and edge detect
    //======================================================================
    always_ff @(posedge clk_safety_gated or negedge rst_n_safety_i) begin
        if (!rst_n_safety_i) begin
            sync_q     <= '0;
            level_d1_q <= 1'b0;
        end else begin
            sync_q     <= {sync_q[SYNC_STAGES-2:0], fault_i};
            level_d1_q <= sync_q[SYNC_STAGES-1];
        end
    end

    // Last stage is about to go high on this edge
    assign rise_next = sync_q[SYNC_STAGES-2] & ~sync_q[SYNC_STAGES-1];

    //======================================================================
    // Code capture
    //======================================================================
    // Loads on the edge that raises the rise pulse, so the code is
    // already valid while the pulse is high. The source keeps the code
    // stable for as long as its line is up.
    always_ff @(posedge clk_safety_gated) begin
        if (rise_next) begin
            code_q <= fault_code_i;
        end
    end

    assign fault_level_o = sync_q[SYNC_STAGES-1];
    assign fault_rise_o  = sync_q[SYNC_STAGES-1] & ~level_d1_q;
    assign fault_code_o  = code_q;

endmodule

`default_nettype wire

// ==== safety_fsm/safety_fsm.sv ====
//==========================================================================
// Safety state machine of the island
// Walks normal, warning, safe, reset and fault from the synchronized
// fault levels, counts error cycles in warning and requests a reset
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module safety_fsm (
    input  logic                                clk_safety_gated,
    input  logic                                rst_n_safety_i,
    input  logic [safety_pkg::NUM_CHANNELS-1:0] fault_level_i,
    output safety_pkg::safety_state_t           state_o,
    output logic                                reset_request_o
);

    import safety_pkg::*;

    safety_state_t         state_q;
    safety_state_t         state_d;
    logic [ACC_WIDTH-1:0]  acc_q;
    logic [ACC_WIDTH-1:0]  acc_d;

    logic                  any_fault;
    logic                  timeout_fault;
    logic                  dual_fault;
    logic                  acc_over;

    //======================================================================
    // Fault conditions
    //======================================================================
    assign any_fault     = |fault_level_i;
    assign timeout_fault = fault_level_i[CH_WD_TIMEOUT];
    // Lockstep and ECC failing together is unrecoverable
    assign dual_fault    = fault_level_i[CH_LOCKSTEP] & fault_level_i[CH_ECC];
    assign acc_over      = (acc_q > ACC_WIDTH'(WARN_LIMIT));

    //======================================================================
    // Next state
    //======================================================================
    always_comb begin
        state_d = state_q;
        acc_d   = acc_q;

        case (state_q)
            ST_NORMAL: begin
                if (any_fault) begin
                    state_d = ST_WARNING;
                    acc_d   = ACC_WIDTH'(1);
                end
            end

            ST_WARNING: begin
                // Count every cycle with an active fault
                if (any_fault) begin
                    acc_d = acc_q + ACC_WIDTH'(1);
                end

                if (timeout_fault) begin
                    state_d = ST_RESET;
                end else if (acc_over) begin
                    state_d = ST_SAFE;
                end else if (!any_fault) begin
                    state_d = ST_NORMAL;
                end
            end

            ST_SAFE: begin
                if (dual_fault) begin
                    state_d = ST_FAULT;
                end else if (timeout_fault) begin
                    state_d = ST_RESET;
                end
            end

            // Reset request is high for this single cycle
            ST_RESET: begin
                state_d = ST_NORMAL;
            end

            // Only leaves through reset
            ST_FAULT: begin
                state_d = ST_FAULT;
            end

            default: begin
                state_d = ST_NORMAL;
            end
        endcase
    end

    //======================================================================
    // State and accumulator registers
    //======================================================================
    always_ff @(posedge clk_safety_gated or negedge rst_n_safety_i) begin
        if (!rst_n_safety_i) begin
            state_q <= ST_NORMAL;
            acc_q   <= '0;
        end else begin
            state_q <= state_d;
            acc_q   <= acc_d;
        end
    end

    assign state_o         = state_q;
    assign reset_request_o = (state_q == ST_RESET);

endmodule

`default_nettype wire

// ==== src/error_report.sv ====
//==========================================================================
// Error reporter that registers the code of the highest priority rising
// channel with a one-cycle valid strobe and builds the interrupt lines
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module error_report (
    input  logic                                clk_safety_gated,
    input  logic                                rst_n_safety_i,
    input  logic [safety_pkg::NUM_CHANNELS-1:0] fault_level_i,
    input  logic [safety_pkg::NUM_CHANNELS-1:0] fault_rise_i,
    input  logic [safety_pkg::NUM_CHANNELS-1:0]
                 [safety_pkg::CODE_WIDTH-1:0]   fault_code_i,
    input  safety_pkg::safety_state_t           state_i,
    output logic [safety_pkg::CODE_WIDTH-1:0]   error_code_o,
    output logic                                error_valid_o,
    output logic [safety_pkg::IRQ_WIDTH-1:0]    irq_o,
    output logic                                irq_fault_o
);

    import safety_pkg::*;

    logic                  any_rise;
    logic [CODE_WIDTH-1:0] sel_code;
    logic                  detected;

    //======================================================================
    // Priority select
    //======================================================================
    assign any_rise = |fault_rise_i;

    // Walk down so the lowest rising index is written last
    always_comb begin
        sel_code = '0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (fault_rise_i[i]) begin
                sel_code = fault_code_i[i];
            end
        end
    end

    always_ff @(posedge clk_safety_gated or negedge rst_n_safety_i) begin
        if (!rst_n_safety_i) begin
            error_code_o  <= '0;
            error_valid_o <= 1'b0;
        end else begin
            error_valid_o <= any_rise;
            // Code holds between reports
            if (any_rise) begin
                error_code_o <= sel_code;
            end
        end
    end

    //======================================================================
    // Interrupts
    //======================================================================
    assign detected = (state_i != ST_NORMAL);

    assign irq_o[IRQ_LOCKSTEP] = fault_level_i[CH_LOCKSTEP];
    assign irq_o[IRQ_ECC]      = fault_level_i[CH_ECC];
    assign irq_o[IRQ_WATCHDOG] = fault_level_i[CH_WD_ERROR] | fault_level_i[CH_WD_TIMEOUT];
    assign irq_o[IRQ_DETECTED] = detected;
    assign irq_o[IRQ_SAFE]     = (state_i == ST_SAFE);
    assign irq_o[IRQ_FAULT]    = (state_i == ST_FAULT);

    // Timeout alone reaches the fault line only through detected
    assign irq_fault_o = fault_level_i[CH_LOCKSTEP] | fault_level_i[CH_ECC]
                       | fault_level_i[CH_WD_ERROR] | detected;

endmodule

`default_nettype wire

// ==== src/safety_island_top.sv ====
//==========================================================================
// Top level of the safety island supervisor
// Four fault channels feed the safety state machine and the error
// reporter, all on the gated safety clock
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module safety_island_top (
    input  logic                                clk_safety_gated,
    input  logic                                rst_n_safety_i,
    input  logic [safety_pkg::NUM_CHANNELS-1:0] fault_i,
    input  logic [safety_pkg::NUM_CHANNELS-1:0]
                 [safety_pkg::CODE_WIDTH-1:0]   fault_code_i,
    output logic [safety_pkg::CODE_WIDTH-1:0]   error_code_o,
    output logic                                error_valid_o,
    output logic [safety_pkg::IRQ_WIDTH-1:0]    irq_o,
    output logic                                irq_fault_o,
    output logic                                reset_request_o
);

    import safety_pkg::*;

    logic [NUM_CHANNELS-1:0]                 fault_level;
    logic [NUM_CHANNELS-1:0]                 fault_rise;
    logic [NUM_CHANNELS-1:0][CODE_WIDTH-1:0] fault_code;
    safety_state_t                           safety_state;

    //======================================================================
    // Fault channels in reporting priority order
    //======================================================================
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        fault_channel fault_channel_i (
            .clk_safety_gated (clk_safety_gated),
            .rst_n_safety_i   (rst_n_safety_i),
            .fault_i          (fault_i[ch]),
            .fault_code_i     (fault_code_i[ch]),
            .fault_level_o    (fault_level[ch]),
            .fault_rise_o     (fault_rise[ch]),
            .fault_code_o     (fault_code[ch])
        );
    end

    //======================================================================
    // State machine and reporting
    //======================================================================
    safety_fsm safety_fsm_i (
        .clk_safety_gated (clk_safety_gated),
        .rst_n_safety_i   (rst_n_safety_i),
        .fault_level_i    (fault_level),
        .state_o          (safety_state),
        .reset_request_o  (reset_request_o)
    );

    error_report error_report_i (
        .clk_safety_gated (clk_safety_gated),
        .rst_n_safety_i   (rst_n_safety_i),
        .fault_level_i    (fault_level),
        .fault_rise_i     (fault_rise),
        .fault_code_i     (fault_code),
        .state_i          (safety_state),
        .error_code_o     (error_code_o),
        .error_valid_o    (error_valid_o),
        .irq_o            (irq_o),
        .irq_fault_o      (irq_fault_o)
    );

endmodule

`default_nettype wire

// ==== bench/safety_island_sva.sv ====
//==========================================================================
// Concurrent checks on the safety island outputs
// Bound into the top level of the island
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module safety_island_sva (
    input  logic                             clk_safety_gated,
    input  logic                             rst_n_safety_i,
    input  logic                             error_valid_i,
    input  logic                             reset_request_i,
    input  logic [safety_pkg::IRQ_WIDTH-1:0] irq_i
);

    import safety_pkg::*;

    // One strobe per report
    a_valid_single: assert property (@(posedge clk_safety_gated) disable iff (!rst_n_safety_i)
        error_valid_i |=> !error_valid_i)
        else $error("error_valid_o high on two cycles in a row");

    a_reset_request_single: assert property (@(posedge clk_safety_gated)
        disable iff (!rst_n_safety_i) reset_request_i |=> !reset_request_i)
        else $error("reset_request_o held longer than one cycle");

    a_safe_fault_exclusive: assert property (@(posedge clk_safety_gated)
        disable iff (!rst_n_safety_i) !(irq_i[IRQ_SAFE] && irq_i[IRQ_FAULT]))
        else $error("safe and fault interrupts high together");

    // Fault state is left only through reset
    a_fault_sticky: assert property (@(posedge clk_safety_gated) disable iff (!rst_n_safety_i)
        irq_i[IRQ_FAULT] |=> irq_i[IRQ_FAULT])
        else $error("fault interrupt dropped without reset");

endmodule

bind safety_island_top safety_island_sva safety_island_sva_i (
    .clk_safety_gated (clk_safety_gated),
    .rst_n_safety_i   (rst_n_safety_i),
    .error_valid_i    (error_valid_o),
    .reset_request_i  (reset_request_o),
    .irq_i            (irq_o)
);

`default_nettype wire

// ==== bench/tb_safety_island.sv ====
//==========================================================================
// Directed testbench of the safety island supervisor
// Drives the fault lines on the falling clock edge and checks codes,
// strobes, interrupts and the reset request against the expected behavior
//==========================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_safety_island;

    import safety_pkg::*;

    logic                                    clk_safety_gated;
    logic                                    rst_n_safety_i;
    logic [NUM_CHANNELS-1:0]                 fault_i;
    logic [NUM_CHANNELS-1:0][CODE_WIDTH-1:0] fault_code_i;
    logic [CODE_WIDTH-1:0]                   error_code_o;
    logic                                    error_valid_o;
    logic [IRQ_WIDTH-1:0]                    irq_o;
    logic                                    irq_fault_o;
    logic                                    reset_request_o;

    logic [31:0]           lfsr_q;
    logic [CODE_WIDTH-1:0] last_code = '0;
    int                    valid_count = 0;
    int                    reset_count = 0;
    int                    error_count = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    safety_island_top safety_island_top_i (
        .clk_safety_gated (clk_safety_gated),
        .rst_n_safety_i   (rst_n_safety_i),
        .fault_i          (fault_i),
        .fault_code_i     (fault_code_i),
        .error_code_o     (error_code_o),
        .error_valid_o    (error_valid_o),
        .irq_o            (irq_o),
        .irq_fault_o      (irq_fault_o),
        .reset_request_o  (reset_request_o)
    );

    initial begin
        clk_safety_gated = 1'b0;
        forever #5 clk_safety_gated = ~clk_safety_gated;
    end

    // Counts the strobes of the cycle that ends at this edge
    always @(posedge clk_safety_gated) begin
        if (error_valid_o) begin
            valid_count = valid_count + 1;
            last_code   = error_code_o;
        end
        if (reset_request_o) begin
            reset_count = reset_count + 1;
        end
    end

    //======================================================================
    // Helpers
    //======================================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_code(output logic [CODE_WIDTH-1:0] code);
        code = '0;
        for (int b = 0; b < CODE_WIDTH; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            code   = {code[CODE_WIDTH-2:0], lfsr_q[0]};
        end
    endtask

    task automatic log_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic log_timeout(input string what, input int max_cycles);
        $display("timeout at %0t ns: %s did not happen within %0d cycles",
                 $time, what, max_cycles);
        error_count++;
    endtask

    task automatic apply_reset();
        @(negedge clk_safety_gated);
        rst_n_safety_i = 1'b0;
        fault_i        = '0;
        repeat (16) @(negedge clk_safety_gated);
        rst_n_safety_i = 1'b1;
    endtask

    task automatic wait_irq(input int idx, input logic value, input int max_cycles,
                            output int cycles);
        cycles = 0;
        while (irq_o[idx[2:0]] !== value && cycles < max_cycles) begin
            @(negedge clk_safety_gated);
            cycles++;
        end
        if (irq_o[idx[2:0]] !== value) begin
            log_timeout($sformatf("irq_o[%0d] going to %0b", idx, value), max_cycles);
        end
    endtask

    task automatic wait_counts(input int valid_target, input int reset_target,
                               input int max_cycles);
        int n;
        n = 0;
        while ((valid_count < valid_target || reset_count < reset_target)
               && n < max_cycles) begin
            @(negedge clk_safety_gated);
            n++;
        end
        if (valid_count < valid_target || reset_count < reset_target) begin
            log_timeout("error strobe or reset request", max_cycles);
        end
    endtask

    // All interrupts and the reset request low
    task automatic wait_idle(input int max_cycles);
        int n;
        n = 0;
        while ((irq_o != '0 || irq_fault_o || reset_request_o) && n < max_cycles) begin
            @(negedge clk_safety_gated);
            n++;
        end
        if (irq_o != '0 || irq_fault_o || reset_request_o) begin
            log_timeout("return of all outputs to idle", max_cycles);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - errors_before);
        end
    endtask

    //======================================================================
    // Directed tests
    //======================================================================
    task automatic check_reset_state();
        int errors_before;
        int valid_base;
        errors_before = error_count;
        apply_reset();
        valid_base = valid_count;
        if (irq_o !== '0 || irq_fault_o !== 1'b0 || reset_request_o !== 1'b0) begin
            log_error($sformatf("irq %b, irq_fault %b, reset request %b after reset",
                                irq_o, irq_fault_o, reset_request_o));
        end
        if (error_valid_o !== 1'b0 || error_code_o !== '0) begin
            log_error($sformatf("valid %b, code %h after reset", error_valid_o, error_code_o));
        end
        repeat (20) @(negedge clk_safety_gated);
        if (valid_count != valid_base) begin
            log_error("error_valid_o pulsed with idle inputs");
        end
        report_test("reset state", errors_before);
    endtask

    task automatic run_lockstep_fault();
        logic [CODE_WIDTH-1:0] code;
        int errors_before;
        int valid_base;
        int cycles;
        errors_before = error_count;
        valid_base    = valid_count;
        draw_code(code);
        fault_code_i[CH_LOCKSTEP] = code;
        @(negedge clk_safety_gated);
        fault_i[CH_LOCKSTEP] = 1'b1;
        wait_counts(valid_base + 1, reset_count, 10);
        if (last_code !== code) begin
            log_error($sformatf("reported code %h, expected %h", last_code, code));
        end
        wait_irq(IRQ_DETECTED, 1'b1, 10, cycles);
        if (irq_o[IRQ_LOCKSTEP] !== 1'b1 || irq_fault_o !== 1'b1) begin
            log_error($sformatf("irq %b, irq_fault %b with lockstep up", irq_o, irq_fault_o));
        end
        repeat (3) @(negedge clk_safety_gated);
        fault_i[CH_LOCKSTEP] = 1'b0;
        wait_idle(20);
        if (valid_count != valid_base + 1) begin
            log_error($sformatf("%0d strobes, expected 1", valid_count - valid_base));
        end
        report_test("short lockstep fault", errors_before);
    endtask

    task automatic ecc_into_safe();
        logic [CODE_WIDTH-1:0] code;
        int errors_before;
        int cycles;
        errors_before = error_count;
        apply_reset();
        draw_code(code);
        fault_code_i[CH_ECC] = code;
        @(negedge clk_safety_gated);
        fault_i[CH_ECC] = 1'b1;
        wait_irq(IRQ_SAFE, 1'b1, WARN_LIMIT + 6, cycles);
        if (cycles < WARN_LIMIT) begin
            log_error($sformatf("safe state after %0d cycles, below the limit", cycles));
        end
        if (last_code !== code) begin
            log_error($sformatf("reported code %h, expected %h", last_code, code));
        end
        // Safe holds once the fault goes away
        fault_i[CH_ECC] = 1'b0;
        wait_irq(IRQ_ECC, 1'b0, 10, cycles);
        if (irq_o[IRQ_SAFE] !== 1'b1) begin
            log_error("safe state left without a further fault");
        end
        report_test("long ECC fault", errors_before);
    endtask

    task automatic dual_fault_lock();
        logic [CODE_WIDTH-1:0] code;
        int errors_before;
        int cycles;
        errors_before = error_count;
        draw_code(code);
        fault_code_i[CH_LOCKSTEP] = code;
        fault_code_i[CH_ECC]      = ~code;
        @(negedge clk_safety_gated);
        fault_i[CH_LOCKSTEP] = 1'b1;
        fault_i[CH_ECC]      = 1'b1;
        wait_irq(IRQ_FAULT, 1'b1, 10, cycles);
        fault_i = '0;
        wait_irq(IRQ_LOCKSTEP, 1'b0, 10, cycles);
        wait_irq(IRQ_ECC, 1'b0, 10, cycles);
        repeat (4) @(negedge clk_safety_gated);
        if (irq_o[IRQ_FAULT] !== 1'b1 || irq_o[IRQ_SAFE] !== 1'b0) begin
            log_error($sformatf("irq %b after the dual fault cleared", irq_o));
        end
        if (last_code !== code) begin
            log_error($sformatf("reported code %h, expected lockstep %h", last_code, code));
        end
        report_test("dual fault from safe", errors_before);
    endtask

    task automatic watchdog_reset_pulse();
        logic [CODE_WIDTH-1:0] code;
        int errors_before;
        int reset_base;
        int cycles;
        errors_before = error_count;
        apply_reset();
        reset_base = reset_count;
        draw_code(code);
        fault_code_i[CH_WD_ERROR]   = code;
        fault_code_i[CH_WD_TIMEOUT] = ~code;
        @(negedge clk_safety_gated);
        fault_i[CH_WD_ERROR] = 1'b1;
        wait_irq(IRQ_DETECTED, 1'b1, 10, cycles);
        if (irq_o[IRQ_WATCHDOG] !== 1'b1 || irq_fault_o !== 1'b1) begin
            log_error($sformatf("irq %b, irq_fault %b with watchdog error up",
                                irq_o, irq_fault_o));
        end
        // Short timeout pulse that ends before warning is entered again
        fault_i[CH_WD_TIMEOUT] = 1'b1;
        repeat (2) @(negedge clk_safety_gated);
        fault_i[CH_WD_TIMEOUT] = 1'b0;
        wait_counts(valid_count, reset_base + 1, 15);
        repeat (4) @(negedge clk_safety_gated);
        fault_i[CH_WD_ERROR] = 1'b0;
        wait_irq(IRQ_DETECTED, 1'b0, 20, cycles);
        if (reset_count != reset_base + 1) begin
            log_error($sformatf("%0d reset requests, expected 1", reset_count - reset_base));
        end
        report_test("watchdog timeout in warning", errors_before);
    endtask

    task automatic same_edge_priority();
        logic [CODE_WIDTH-1:0] ecc_code;
        logic [CODE_WIDTH-1:0] wd_code;
        int errors_before;
        int valid_base;
        errors_before = error_count;
        valid_base    = valid_count;
        draw_code(ecc_code);
        draw_code(wd_code);
        if (wd_code == ecc_code) begin
            wd_code = ~ecc_code;
        end
        fault_code_i[CH_ECC]      = ecc_code;
        fault_code_i[CH_WD_ERROR] = wd_code;
        @(negedge clk_safety_gated);
        fault_i[CH_ECC]      = 1'b1;
        fault_i[CH_WD_ERROR] = 1'b1;
        wait_counts(valid_base + 1, reset_count, 10);
        repeat (3) @(negedge clk_safety_gated);
        fault_i = '0;
        wait_idle(20);
        if (valid_count != valid_base + 1) begin
            log_error($sformatf("%0d strobes, expected 1", valid_count - valid_base));
        end
        if (last_code !== ecc_code || error_code_o !== ecc_code) begin
            log_error($sformatf("reported code %h, expected ECC %h", last_code, ecc_code));
        end
        report_test("same edge priority", errors_before);
    endtask

    //======================================================================
    // Test sequence
    //======================================================================
    initial begin
        rst_n_safety_i = 1'b0;
        fault_i        = '0;
        fault_code_i   = '0;
        lfsr_q         = 32'hfad5_ba79;

        check_reset_state();
        run_lockstep_fault();
        ecc_into_safe();
        dual_fault_lock();
        watchdog_reset_pulse();
        same_edge_priority();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/safety_pkg.sv
src/fault_channel.sv
safety_fsm/safety_fsm.sv
src/error_report.sv
src/safety_island_top.sv
bench/safety_island_sva.sv
bench/tb_safety_island.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the safety island testbench with Verilator, runs it and
# looks for the pass line in the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_safety_island \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_safety_island > sim.log 2>&1 \
    ; grep -qx "RESULT: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
